// ==== source/rob_defs.svh ====
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// nick 0 is reserved for "no producer"
`define ROB_NICK_W 5

// usable entries, nicks 1 .. 31
`define ROB_DEPTH 31

// architectural register index
`define REG_NAME_W 5

// result value
`define DATA_W 32

// jump target
`define ADDR_W 32

// internal opcode
`define OP_W 6

`endif

// ==== source/rob_pkg.sv ====
`default_nettype none

`include "rob_defs.svh"

package rob_pkg;

    typedef logic [`ROB_NICK_W-1:0] nick_t;
    typedef logic [`REG_NAME_W-1:0] reg_name_t;
    typedef logic [`DATA_W-1:0]     data_t;
    typedef logic [`ADDR_W-1:0]     addr_t;
    typedef logic [`OP_W-1:0]       op_t;

    // store opcodes of the internal encoding
    localparam op_t OP_SB = 6'd26;
    localparam op_t OP_SH = 6'd27;
    localparam op_t OP_SW = 6'd28;

    // what the head does at the next edge
    typedef enum logic [1:0] {
        COMMIT_NONE,
        COMMIT_WB,
        COMMIT_STORE,
        COMMIT_REDIRECT
    } commit_kind_t;

    function automatic logic is_store(op_t op);
        return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
    endfunction

    // wraps from the last nick back to 1, never 0
    function automatic nick_t next_nick(nick_t n);
        return (n == nick_t'(`ROB_DEPTH)) ? nick_t'(1) : n + nick_t'(1);
    endfunction

endpackage

`default_nettype wire

// ==== source/rob_alloc.sv ====
`default_nettype none

`include "rob_defs.svh"

module rob_alloc (
    input  wire                clk,
    input  wire                rst,
    input  wire                rdy,
    input  wire                flush,
    input  wire                alloc_req,
    input  rob_pkg::reg_name_t alloc_regnm,
    input  wire                retire_en,
    output logic               full,
    output logic               nick_en,
    output rob_pkg::nick_t     nick,
    output rob_pkg::reg_name_t nick_regnm
);
    import rob_pkg::*;

    localparam logic [`ROB_NICK_W:0] DEPTH_CNT = `ROB_DEPTH;

    nick_t                 tail;
    logic [`ROB_NICK_W:0]  count;
    logic [`ROB_NICK_W:0]  count_next;

    // grant answered in the same cycle as the request
    assign nick_en    = rdy && alloc_req && !full;
    assign nick       = nick_en ? tail : '0;
    assign nick_regnm = alloc_regnm;

    always_comb begin
        count_next = count;
        if (nick_en && !retire_en) begin
            count_next = count + 1'b1;
        end else if (retire_en && !nick_en) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || (rdy && flush)) begin
            tail  <= nick_t'(1);
            count <= '0;
            full  <= 1'b0;
        end else if (rdy) begin
            if (nick_en) begin
                tail <= next_nick(tail);
            end
            count <= count_next;
            full  <= (count_next == DEPTH_CNT);
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst) count <= DEPTH_CNT);

endmodule

`default_nettype wire

// ==== source/rob_entries.sv ====
`default_nettype none

`include "rob_defs.svh"

module rob_entries (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   rdy,
    input  wire                   flush,
    // dispatch
    input  wire                   dp_en,
    input  rob_pkg::nick_t        dp_nick,
    input  rob_pkg::op_t          dp_op,
    input  wire                   dp_pd,
    input  rob_pkg::reg_name_t    dp_regnm,
    // execute results
    input  wire                   ex_en,
    input  rob_pkg::nick_t        ex_nick,
    input  rob_pkg::data_t        ex_dt,
    input  wire                   ex_ac,
    input  rob_pkg::addr_t        ex_j_pc,
    // store/load buffer results
    input  wire                   slb_en,
    input  rob_pkg::nick_t        slb_nick,
    input  rob_pkg::data_t        slb_dt,
    // from commit
    input  rob_pkg::nick_t        head,
    input  wire                   retire_en,
    input  rob_pkg::commit_kind_t retire_kind,
    input  wire                   release_en,
    output logic                  head_valid,
    output logic                  head_done,
    output logic                  head_store,
    output logic                  head_released,
    output logic                  head_mispredict,
    output rob_pkg::reg_name_t    head_regnm,
    output rob_pkg::data_t        head_dt,
    output rob_pkg::addr_t        head_j_pc
);
    import rob_pkg::*;

    // slot 0 exists but is never written
    logic [`ROB_DEPTH:0] valid;
    logic [`ROB_DEPTH:0] done;
    logic [`ROB_DEPTH:0] store;
    logic [`ROB_DEPTH:0] released;
    logic [`ROB_DEPTH:0] pd;
    logic [`ROB_DEPTH:0] ac;
    reg_name_t           regnm [0:`ROB_DEPTH];
    data_t               dt    [0:`ROB_DEPTH];
    addr_t               j_pc  [0:`ROB_DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid    <= '0;
            done     <= '0;
            store    <= '0;
            released <= '0;
        end else if (rdy) begin
            if (flush) begin
                valid    <= '0;
                done     <= '0;
                store    <= '0;
                released <= '0;
            end else begin
                if (dp_en) begin
                    valid[dp_nick]    <= 1'b1;
                    done[dp_nick]     <= 1'b0;
                    store[dp_nick]    <= is_store(dp_op);
                    released[dp_nick] <= 1'b0;
                    pd[dp_nick]       <= dp_pd;
                    // no mispredict unless execute says otherwise
                    ac[dp_nick]       <= dp_pd;
                    regnm[dp_nick]    <= dp_regnm;
                end
                if (ex_en) begin
                    done[ex_nick] <= 1'b1;
                    dt[ex_nick]   <= ex_dt;
                    ac[ex_nick]   <= ex_ac;
                    j_pc[ex_nick] <= ex_j_pc;
                end
                if (slb_en) begin
                    if (store[slb_nick]) begin
                        // store counts as done only once it was released
                        if (released[slb_nick]) begin
                            done[slb_nick] <= 1'b1;
                        end
                    end else begin
                        done[slb_nick] <= 1'b1;
                        dt[slb_nick]   <= slb_dt;
                    end
                end
                if (release_en) begin
                    released[head] <= 1'b1;
                end
                if (retire_en) begin
                    valid[head]    <= 1'b0;
                    done[head]     <= 1'b0;
                    store[head]    <= 1'b0;
                    released[head] <= 1'b0;
                end
            end
        end
    end

    assign head_valid      = valid[head];
    assign head_done       = done[head];
    assign head_store      = store[head];
    assign head_released   = released[head];
    assign head_mispredict = pd[head] != ac[head];
    assign head_regnm      = regnm[head];
    assign head_dt         = dt[head];
    assign head_j_pc       = j_pc[head];

    a_ex_target: assert property (@(posedge clk) disable iff (rst)
        ex_en |-> (ex_nick != '0) && valid[ex_nick]);

    a_slb_target: assert property (@(posedge clk) disable iff (rst)
        slb_en |-> (slb_nick != '0) && valid[slb_nick]);

    // a store may only leave after the store/load buffer confirmed it
    a_store_retire: assert property (@(posedge clk) disable iff (rst)
        retire_en && (retire_kind == COMMIT_STORE) |-> store[head] && released[head]);

endmodule

`default_nettype wire

// ==== source/rob_commit.sv ====
`default_nettype none

module rob_commit (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   rdy,
    input  wire                   clr_in,
    input  wire                   head_valid,
    input  wire                   head_done,
    input  wire                   head_store,
    input  wire                   head_released,
    input  wire                   head_mispredict,
    input  rob_pkg::reg_name_t    head_regnm,
    input  rob_pkg::data_t        head_dt,
    input  rob_pkg::addr_t        head_j_pc,
    output rob_pkg::nick_t        head,
    output logic                  retire_en,
    output rob_pkg::commit_kind_t retire_kind,
    output logic                  release_en,
    output logic                  flush,
    // register file write-back
    output logic                  rf_en,
    output rob_pkg::reg_name_t    rf_regnm,
    output rob_pkg::data_t        rf_dt,
    output rob_pkg::nick_t        rf_nick,
    // store release
    output logic                  store_en,
    output rob_pkg::nick_t        store_nick,
    // fetch redirect
    output logic                  jump_en,
    output rob_pkg::addr_t        jump_pc
);
    import rob_pkg::*;

    logic writes_back;

    // retire decision for the current head
    always_comb begin
        retire_kind = COMMIT_NONE;
        release_en  = 1'b0;
        if (rdy && !clr_in && head_valid) begin
            if (head_store) begin
                if (head_done) begin
                    retire_kind = COMMIT_STORE;
                end else if (!head_released) begin
                    release_en = 1'b1;
                end
            end else if (head_done) begin
                retire_kind = head_mispredict ? COMMIT_REDIRECT : COMMIT_WB;
            end
        end
    end

    assign retire_en   = retire_kind != COMMIT_NONE;
    assign writes_back = (retire_kind == COMMIT_WB) || (retire_kind == COMMIT_REDIRECT);
    assign flush       = (rdy && clr_in) || (retire_kind == COMMIT_REDIRECT);

    always_ff @(posedge clk) begin
        if (rst) begin
            head     <= nick_t'(1);
            rf_en    <= 1'b0;
            store_en <= 1'b0;
            jump_en  <= 1'b0;
        end else if (!rdy) begin
            rf_en    <= 1'b0;
            store_en <= 1'b0;
            jump_en  <= 1'b0;
        end else begin
            rf_en    <= writes_back;
            store_en <= release_en;
            jump_en  <= retire_kind == COMMIT_REDIRECT;
            if (writes_back) begin
                rf_regnm <= head_regnm;
                rf_dt    <= head_dt;
                rf_nick  <= head;
            end
            if (release_en) begin
                store_nick <= head;
            end
            if (retire_kind == COMMIT_REDIRECT) begin
                jump_pc <= head_j_pc;
            end
            if (flush) begin
                head <= nick_t'(1);
            end else if (retire_en) begin
                head <= next_nick(head);
            end
        end
    end

    a_jump_store_excl: assert property (@(posedge clk) disable iff (rst)
        !(jump_en && store_en));

endmodule

`default_nettype wire

// ==== source/reg_rename.sv ====
`default_nettype none

`include "rob_defs.svh"

module reg_rename (
    input  wire                clk,
    input  wire                rst,
    input  wire                rdy,
    input  wire                flush,
    // allocation announce
    input  wire                nick_en,
    input  rob_pkg::nick_t     nick,
    input  rob_pkg::reg_name_t nick_regnm,
    // commit
    input  wire                rf_en,
    input  rob_pkg::reg_name_t rf_regnm,
    input  rob_pkg::nick_t     rf_nick,
    // lookup
    input  rob_pkg::reg_name_t rs_a,
    input  rob_pkg::reg_name_t rs_b,
    output rob_pkg::nick_t     rd_nick_a,
    output rob_pkg::nick_t     rd_nick_b
);
    import rob_pkg::*;

    // pending producer per architectural register, 0 when none
    nick_t tbl [0:(1 << `REG_NAME_W)-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            tbl <= '{default: '0};
        end else if (rdy) begin
            if (flush) begin
                tbl <= '{default: '0};
            end else begin
                // only clear if no younger producer took over
                if (rf_en && (tbl[rf_regnm] == rf_nick)) begin
                    tbl[rf_regnm] <= '0;
                end
                // new allocation wins over a clear of the same register
                if (nick_en && (nick_regnm != '0)) begin
                    tbl[nick_regnm] <= nick;
                end
            end
        end
    end

    assign rd_nick_a = (rs_a == '0) ? '0 : tbl[rs_a];
    assign rd_nick_b = (rs_b == '0) ? '0 : tbl[rs_b];

endmodule

`default_nettype wire

// ==== source/rob_top.sv ====
`default_nettype none

module rob_top (
    input  wire                clk,
    input  wire                rst,
    input  wire                rdy,
    input  wire                clr_in,
    input  wire                alloc_req,
    input  rob_pkg::reg_name_t alloc_regnm,
    output logic               full,
    output logic               nick_en,
    output rob_pkg::nick_t     nick,
    output rob_pkg::reg_name_t nick_regnm,
    input  wire                dp_en,
    input  rob_pkg::nick_t     dp_nick,
    input  rob_pkg::op_t       dp_op,
    input  wire                dp_pd,
    input  rob_pkg::reg_name_t dp_regnm,
    input  wire                ex_en,
    input  rob_pkg::nick_t     ex_nick,
    input  rob_pkg::data_t     ex_dt,
    input  wire                ex_ac,
    input  rob_pkg::addr_t     ex_j_pc,
    input  wire                slb_en,
    input  rob_pkg::nick_t     slb_nick,
    input  rob_pkg::data_t     slb_dt,
    input  rob_pkg::reg_name_t rs_a,
    input  rob_pkg::reg_name_t rs_b,
    output rob_pkg::nick_t     rd_nick_a,
    output rob_pkg::nick_t     rd_nick_b,
    output logic               rf_en,
    output rob_pkg::reg_name_t rf_regnm,
    output rob_pkg::data_t     rf_dt,
    output rob_pkg::nick_t     rf_nick,
    output logic               store_en,
    output rob_pkg::nick_t     store_nick,
    output logic               jump_en,
    output rob_pkg::addr_t     jump_pc
);
    import rob_pkg::*;

    nick_t        head;
    logic         head_valid;
    logic         head_done;
    logic         head_store;
    logic         head_released;
    logic         head_mispredict;
    reg_name_t    head_regnm;
    data_t        head_dt;
    addr_t        head_j_pc;
    logic         retire_en;
    commit_kind_t retire_kind;
    logic         release_en;
    logic         flush;

    rob_alloc u_alloc (
        .clk, .rst, .rdy, .flush, .alloc_req, .alloc_regnm, .retire_en,
        .full, .nick_en, .nick, .nick_regnm
    );

    rob_entries u_entries (
        .clk, .rst, .rdy, .flush,
        .dp_en, .dp_nick, .dp_op, .dp_pd, .dp_regnm,
        .ex_en, .ex_nick, .ex_dt, .ex_ac, .ex_j_pc,
        .slb_en, .slb_nick, .slb_dt,
        .head, .retire_en, .retire_kind, .release_en,
        .head_valid, .head_done, .head_store, .head_released, .head_mispredict,
        .head_regnm, .head_dt, .head_j_pc
    );

    rob_commit u_commit (
        .clk, .rst, .rdy, .clr_in,
        .head_valid, .head_done, .head_store, .head_released, .head_mispredict,
        .head_regnm, .head_dt, .head_j_pc,
        .head, .retire_en, .retire_kind, .release_en, .flush,
        .rf_en, .rf_regnm, .rf_dt, .rf_nick,
        .store_en, .store_nick, .jump_en, .jump_pc
    );

    reg_rename u_rename (
        .clk, .rst, .rdy, .flush,
        .nick_en, .nick, .nick_regnm,
        .rf_en, .rf_regnm, .rf_nick,
        .rs_a, .rs_b, .rd_nick_a, .rd_nick_b
    );

endmodule

`default_nettype wire

// ==== tests/tb_rob_top.sv ====
`default_nettype none

`include "rob_defs.svh"

module tb_rob_top;
    timeunit 1ns;
    timeprecision 100ps;

    import rob_pkg::*;

    localparam int  CLK_PERIOD = 40;
    localparam int  NUM_ROWS   = 7;
    localparam int  NO_MIS     = 63;
    localparam op_t OP_ALU     = 6'd1;

    // instruction count, store mask, mispredict index, rdy stalls
    typedef struct packed {
        logic [5:0]  count;
        logic [31:0] store_mask;
        logic [5:0]  mis_idx;
        logic        stall;
    } row_t;

    logic      clk;
    logic      rst;
    logic      rdy;
    logic      clr_in;
    logic      alloc_req;
    reg_name_t alloc_regnm;
    logic      full;
    logic      nick_en;
    nick_t     nick;
    reg_name_t nick_regnm;
    logic      dp_en;
    nick_t     dp_nick;
    op_t       dp_op;
    logic      dp_pd;
    reg_name_t dp_regnm;
    logic      ex_en;
    nick_t     ex_nick;
    data_t     ex_dt;
    logic      ex_ac;
    addr_t     ex_j_pc;
    logic      slb_en;
    nick_t     slb_nick;
    data_t     slb_dt;
    reg_name_t rs_a;
    reg_name_t rs_b;
    nick_t     rd_nick_a;
    nick_t     rd_nick_b;
    logic      rf_en;
    reg_name_t rf_regnm;
    data_t     rf_dt;
    nick_t     rf_nick;
    logic      store_en;
    nick_t     store_nick;
    logic      jump_en;
    addr_t     jump_pc;

    // reference model state
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    nick_t       tail_m;
    nick_t       tbl [0:(1 << `REG_NAME_W) - 1];
    int          inflight;
    int          cidx;
    int          commit_end;
    int          mis;
    int          store_idx;
    int          pend_cnt;
    int          pend [0:30];
    logic        store_wait;
    logic        slb_todo;
    logic        silent_pend;
    logic        clr_pend;
    logic        rdy_q;
    reg_name_t   clr_reg;
    nick_t       clr_nick;
    nick_t       e_nick  [0:30];
    reg_name_t   e_reg   [0:30];
    data_t       e_dt    [0:30];
    addr_t       e_jpc   [0:30];
    logic        e_pd    [0:30];
    logic        e_store [0:30];
    logic        e_load  [0:30];

    rob_top DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(NUM_ROWS * 200 * CLK_PERIOD);
        $display("Watchdog expired before all scenario rows finished");
        $display("Checks failed");
        $finish;
    end

    function automatic row_t table_row(input int i);
        case (i)
            0:       return {6'd6,  32'h0000_0000, 6'd63, 1'b0};
            1:       return {6'd31, 32'h0000_0000, 6'd63, 1'b0};
            2:       return {6'd12, 32'h0000_0124, 6'd63, 1'b0};
            3:       return {6'd10, 32'h0000_0002, 6'd6,  1'b0};
            4:       return {6'd20, 32'h0001_0040, 6'd63, 1'b1};
            5:       return {6'd31, 32'h4000_0011, 6'd63, 1'b1};
            default: return {6'd9,  32'h0000_0000, 6'd8,  1'b0};
        endcase
    endfunction

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic drive_idle();
        rdy       <= 1'b1;
        clr_in    <= 1'b0;
        alloc_req <= 1'b0;
        dp_en     <= 1'b0;
        ex_en     <= 1'b0;
        slb_en    <= 1'b0;
        rs_a      <= reg_name_t'(rand_bits(5));
        rs_b      <= reg_name_t'(rand_bits(5));
    endtask

    task automatic send_result(input int i);
        if (e_load[i]) begin
            slb_en   <= 1'b1;
            slb_nick <= e_nick[i];
            slb_dt   <= e_dt[i];
        end else begin
            ex_en   <= 1'b1;
            ex_nick <= e_nick[i];
            ex_dt   <= e_dt[i];
            // only the chosen branch resolves against its prediction
            ex_ac   <= (i == mis) ? !e_pd[i] : e_pd[i];
            ex_j_pc <= e_jpc[i];
        end
    endtask

    // called at every falling edge, compares commit outputs in program order
    task automatic observe();
        // a rename clear due at a stalled edge is lost
        if (clr_pend && rdy_q && tbl[clr_reg] == clr_nick) begin
            tbl[clr_reg] = '0;
        end
        clr_pend = 1'b0;
        if (!rdy_q) begin
            check_val("rf_en", rf_en, 1'b0);
            check_val("store_en", store_en, 1'b0);
            check_val("jump_en", jump_en, 1'b0);
        end else if (rf_en || store_en || jump_en) begin
            if (cidx >= commit_end) begin
                errors++;
                $display("Commit output seen with no entry left to commit at %0t ns", $time);
            end else if (store_wait) begin
                errors++;
                $display("Commit output seen before the store was confirmed at %0t ns", $time);
            end else begin
                if (silent_pend) begin
                    inflight--;
                end
                silent_pend = 1'b0;
                check_val("store_en", store_en, e_store[cidx]);
                check_val("rf_en", rf_en, !e_store[cidx]);
                check_val("jump_en", jump_en, cidx == mis);
                if (e_store[cidx]) begin
                    check_val("store_nick", store_nick, e_nick[cidx]);
                    store_idx   = cidx;
                    store_wait  = 1'b1;
                    slb_todo    = 1'b1;
                    silent_pend = 1'b1;
                end else begin
                    check_val("rf_regnm", rf_regnm, e_reg[cidx]);
                    check_val("rf_dt", rf_dt, e_dt[cidx]);
                    check_val("rf_nick", rf_nick, e_nick[cidx]);
                    inflight--;
                    clr_pend = 1'b1;
                    clr_reg  = e_reg[cidx];
                    clr_nick = e_nick[cidx];
                    if (cidx == mis) begin
                        check_val("jump_pc", jump_pc, e_jpc[cidx]);
                        for (int r = 0; r < (1 << `REG_NAME_W); r++) begin
                            tbl[r] = '0;
                        end
                        clr_pend = 1'b0;
                        inflight = 0;
                        tail_m   = nick_t'(1);
                    end
                end
                check_val("full", full, inflight == `ROB_DEPTH);
                cidx++;
            end
        end
        check_val("rd_nick_a", rd_nick_a, tbl[rs_a]);
        check_val("rd_nick_b", rd_nick_b, tbl[rs_b]);
        rdy_q = rdy;
    endtask

    task automatic sweep_rename();
        for (int k = 0; k < 16; k++) begin
            @(posedge clk);
            drive_idle();
            rs_a <= reg_name_t'(2 * k);
            rs_b <= reg_name_t'(2 * k + 1);
            @(negedge clk);
            observe();
        end
    endtask

    initial begin
        row_t r;
        int   n;
        int   k;
        int   idx;
        lfsr        = 32'h17f9_a1b8;
        errors      = 0;
        checks      = 0;
        tail_m      = nick_t'(1);
        inflight    = 0;
        store_idx   = 0;
        store_wait  = 1'b0;
        slb_todo    = 1'b0;
        silent_pend = 1'b0;
        clr_pend    = 1'b0;
        rdy_q       = 1'b1;
        for (int i = 0; i < (1 << `REG_NAME_W); i++) begin
            tbl[i] = '0;
        end
        clk         = 1'b0;
        rst         = 1'b1;
        rdy         = 1'b1;
        clr_in      = 1'b0;
        alloc_req   = 1'b0;
        alloc_regnm = '0;
        dp_en       = 1'b0;
        dp_nick     = '0;
        dp_op       = '0;
        dp_pd       = 1'b0;
        dp_regnm    = '0;
        ex_en       = 1'b0;
        ex_nick     = '0;
        ex_dt       = '0;
        ex_ac       = 1'b0;
        ex_j_pc     = '0;
        slb_en      = 1'b0;
        slb_nick    = '0;
        slb_dt      = '0;
        rs_a        = '0;
        rs_b        = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int ri = 0; ri < NUM_ROWS; ri++) begin
            r          = table_row(ri);
            n          = r.count;
            mis        = (r.mis_idx == NO_MIS) ? -1 : int'(r.mis_idx);
            commit_end = (mis >= 0) ? mis + 1 : n;
            cidx       = 0;
            pend_cnt   = 0;
            for (int i = 0; i < n; i++) begin
                e_store[i] = r.store_mask[i];
                e_reg[i]   = e_store[i] ? '0 : reg_name_t'(rand_bits(5));
                e_dt[i]    = rand_bits(32);
                e_jpc[i]   = rand_bits(32);
                e_pd[i]    = rand_bits(1) != 0;
                e_load[i]  = !e_store[i] && (i != mis) && (rand_bits(1) != 0);
                if (!e_store[i] && (mis < 0 || i <= mis)) begin
                    pend[pend_cnt] = i;
                    pend_cnt++;
                end
            end

            // allocate and dispatch back to back
            for (int i = 0; i < n; i++) begin
                @(posedge clk);
                drive_idle();
                alloc_req   <= 1'b1;
                alloc_regnm <= e_reg[i];
                dp_en       <= 1'b1;
                dp_nick     <= tail_m;
                dp_op       <= e_store[i] ? OP_SW : OP_ALU;
                dp_pd       <= e_pd[i];
                dp_regnm    <= e_reg[i];
                @(negedge clk);
                observe();
                check_val("nick_en", nick_en, 1'b1);
                check_val("nick", nick, tail_m);
                check_val("nick_regnm", nick_regnm, e_reg[i]);
                e_nick[i] = tail_m;
                if (e_reg[i] != '0) begin
                    tbl[e_reg[i]] = tail_m;
                end
                inflight++;
                tail_m = (tail_m == `ROB_DEPTH) ? nick_t'(1) : tail_m + nick_t'(1);
            end

            // a request against a full buffer gets no nick
            @(posedge clk);
            drive_idle();
            alloc_req   <= (inflight == `ROB_DEPTH);
            alloc_regnm <= reg_name_t'(1);
            @(negedge clk);
            observe();
            check_val("full", full, inflight == `ROB_DEPTH);
            check_val("nick_en", nick_en, 1'b0);

            // results in random order, a released store confirms after a random delay
            while (cidx < commit_end || slb_todo) begin
                @(posedge clk);
                drive_idle();
                if (r.stall && rand_bits(2) == 0) begin
                    rdy <= 1'b0;
                end else if (slb_todo && (pend_cnt == 0 || rand_bits(2) == 0)) begin
                    slb_en     <= 1'b1;
                    slb_nick   <= e_nick[store_idx];
                    slb_dt     <= rand_bits(32);
                    slb_todo   = 1'b0;
                    store_wait = 1'b0;
                end else if (pend_cnt > 0) begin
                    k       = int'(rand_bits(5)) % pend_cnt;
                    idx     = pend[k];
                    pend[k] = pend[pend_cnt - 1];
                    pend_cnt--;
                    send_result(idx);
                end
                @(negedge clk);
                observe();
            end

            sweep_rename();
            if (silent_pend) begin
                inflight--;
                silent_pend = 1'b0;
            end
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/rob_pkg.sv
source/rob_alloc.sv
source/rob_entries.sv
source/rob_commit.sv
source/reg_rename.sv
source/rob_top.sv
tests/tb_rob_top.sv

// ==== Bender.yml ====
package:
  name: rob

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/rob_pkg.sv
      - source/rob_alloc.sv
      - source/rob_entries.sv
      - source/rob_commit.sv
      - source/reg_rename.sv
      - source/rob_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/tb_rob_top.sv
